// ==== button_sync.sv ====
`default_nettype none

module button_sync (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            i_btn_mode,
	input  wire            i_btn_pos,
	input  wire            i_btn_inc,
	input  wire            i_btn_alarm,
	output clock_pkg::btn_t o_btn
);

	import clock_pkg::*;

	btn_t raw;
	btn_t sync_q1;
	btn_t sync_q2;
	btn_t prev_q;

	assign raw = '{
		mode:  i_btn_mode,
		pos:   i_btn_pos,
		inc:   i_btn_inc,
		alarm: i_btn_alarm
	};

	// ----------------------------------------------------------
	// Two-flop synchronizer and rising edge
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			prev_q  <= '0;
			o_btn   <= '0;
		end else begin
			sync_q1 <= raw;
			sync_q2 <= sync_q1;
			prev_q  <= sync_q2;
			o_btn   <= btn_t'(sync_q2 & ~prev_q);	// Low then high
		end
	end

endmodule

`default_nettype wire

// ==== clock_pkg.sv ====
`default_nettype none

package clock_pkg;

	// ----------------------------------------------------------
	// Display geometry
	// ----------------------------------------------------------
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

	typedef logic [5:0]            hms_field_t;	// One of hour, minute, second
	typedef logic [3:0]            bcd_t;
	typedef logic [SEG_W-1:0]      seg_t;	// {a, b, c, d, e, f, g}
	typedef logic [NUM_DIGITS-1:0] digit_sel_t;	// Active low
	typedef logic [NUM_DIGITS-1:0] dp_t;

	// ----------------------------------------------------------
	// Field limits
	// ----------------------------------------------------------
	localparam hms_field_t SEC_MAX = 6'd59;
	localparam hms_field_t MIN_MAX = 6'd59;
	localparam hms_field_t HOU_MAX = 6'd23;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_e;

	typedef struct packed {
		hms_field_t hou;
		hms_field_t min;
		hms_field_t sec;
	} hms_t;

	// Single-cycle button pulses
	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm;
	} btn_t;

	typedef struct packed {
		mode_e mode;
		pos_e  pos;
		logic  alarm_en;
	} cfg_t;

endpackage

`default_nettype wire

// ==== digital_clock.sv ====
`default_nettype none

module digital_clock #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int SCAN_DIV      = 50_000
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   i_btn_mode,
	input  wire                   i_btn_pos,
	input  wire                   i_btn_inc,
	input  wire                   i_btn_alarm,
	output clock_pkg::seg_t       o_seg,
	output logic                  o_seg_dp,
	output clock_pkg::digit_sel_t o_seg_enb,
	output logic                  o_alarm
);

	import clock_pkg::*;

	logic sec_tick;
	logic scan_tick;
	btn_t btn;
	cfg_t cfg;
	hms_t cur_time;
	hms_t alarm_set;

	tick_gen #(
		.TICKS_PER_SEC (TICKS_PER_SEC),
		.SCAN_DIV      (SCAN_DIV)
	) u_tick (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_scan_tick (scan_tick)
	);

	button_sync u_btn (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_inc   (i_btn_inc),
		.i_btn_alarm (i_btn_alarm),
		.o_btn       (btn)
	);

	mode_ctrl u_cfg (
		.clk   (clk),
		.rst_n (rst_n),
		.i_btn (btn),
		.o_cfg (cfg)
	);

	time_keeper u_time (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_btn       (btn),
		.i_cfg       (cfg),
		.o_time      (cur_time),
		.o_alarm_set (alarm_set),
		.o_alarm     (o_alarm)
	);

	seg_scan u_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_time      (cur_time),
		.i_alarm_set (alarm_set),
		.i_cfg       (cfg),
		.i_alarm     (o_alarm),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

// ==== mode_ctrl.sv ====
`default_nettype none

module mode_ctrl (
	input  wire             clk,
	input  wire             rst_n,
	input  wire clock_pkg::btn_t i_btn,
	output clock_pkg::cfg_t o_cfg
);

	import clock_pkg::*;

	function automatic mode_e next_mode(mode_e m);
		case (m)
			MODE_CLOCK: return MODE_SETUP;
			MODE_SETUP: return MODE_ALARM;
			default:    return MODE_CLOCK;
		endcase
	endfunction

	function automatic pos_e next_pos(pos_e p);
		case (p)
			POS_SEC: return POS_MIN;
			POS_MIN: return POS_HOU;
			default: return POS_SEC;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_cfg <= '{mode: MODE_CLOCK, pos: POS_SEC, alarm_en: 1'b0};
		end else begin
			if (i_btn.mode) begin
				o_cfg.mode <= next_mode(o_cfg.mode);
				o_cfg.pos  <= POS_SEC;	// Editing restarts at seconds
			end else if (i_btn.pos && o_cfg.mode != MODE_CLOCK) begin
				o_cfg.pos <= next_pos(o_cfg.pos);
			end

			if (i_btn.alarm) begin
				o_cfg.alarm_en <= ~o_cfg.alarm_en;
			end
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		o_cfg.mode inside {MODE_CLOCK, MODE_SETUP, MODE_ALARM});

	a_pos_legal: assert property (@(posedge clk) disable iff (!rst_n)
		o_cfg.pos inside {POS_SEC, POS_MIN, POS_HOU});

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module tb_digital_clock -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "No errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== seg_scan.sv ====
`default_nettype none

module seg_scan (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_scan_tick,
	input  wire clock_pkg::hms_t i_time,
	input  wire clock_pkg::hms_t i_alarm_set,
	input  wire clock_pkg::cfg_t i_cfg,
	input  wire                  i_alarm,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_sel_t o_seg_enb
);

	import clock_pkg::*;

	hms_t       shown;
	bcd_t       digits [NUM_DIGITS];
	dp_t        dp;
	logic [2:0] scan_idx;

	function automatic bcd_t tens(hms_field_t v);
		return bcd_t'(v / 6'd10);
	endfunction

	function automatic bcd_t units(hms_field_t v);
		return bcd_t'(v % 6'd10);
	endfunction

	function automatic seg_t seg_decode(bcd_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// Blank
		endcase
	endfunction

	assign shown = (i_cfg.mode == MODE_ALARM) ? i_alarm_set : i_time;

	// Digit 0 is the rightmost one
	always_comb begin
		digits[0] = units(shown.sec);
		digits[1] = tens(shown.sec);
		digits[2] = units(shown.min);
		digits[3] = tens(shown.min);
		digits[4] = units(shown.hou);
		digits[5] = tens(shown.hou);
	end

	// ----------------------------------------------------------
	// Decimal points
	// ----------------------------------------------------------
	always_comb begin
		dp = '0;
		case (i_cfg.mode)
			MODE_SETUP: dp[{i_cfg.pos, 1'b0}] = 1'b1;	// Units of field
			MODE_ALARM: dp[{i_cfg.pos, 1'b1}] = 1'b1;	// Tens of field
			default:    dp = '0;
		endcase
		if (i_alarm) begin
			dp = '1;
		end
	end

	// ----------------------------------------------------------
	// Scan
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			scan_idx <= (scan_idx == 3'(NUM_DIGITS - 1)) ? 3'd0 : scan_idx + 3'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= 7'b111_1110;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= ~digit_sel_t'(1);
		end else begin
			o_seg     <= seg_decode(digits[scan_idx]);
			o_seg_dp  <= dp[scan_idx];
			o_seg_enb <= ~(digit_sel_t'(1) << scan_idx);
		end
	end

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

// ==== tb.f ====
clock_pkg.sv
tick_gen.sv
button_sync.sv
mode_ctrl.sv
time_keeper.sv
seg_scan.sv
digital_clock.sv
tb_digital_clock.sv

// ==== tb_digital_clock.sv ====
`default_nettype none

module tb_digital_clock;

	import clock_pkg::*;

	localparam int TEST_CYCLES = 16000;	// Dominated by the 3725 s run
	localparam int LIMIT       = TEST_CYCLES * 3 / 2;

	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_INC   = 2;
	localparam int B_ALARM = 3;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       btn_mode;
	logic       btn_pos;
	logic       btn_inc;
	logic       btn_alarm;
	seg_t       seg;
	logic       seg_dp;
	digit_sel_t seg_enb;
	logic       alarm;

	int          cyc = 0;
	int          errors = 0;
	int          lost = 0;	// Seconds held back while in setup
	int          last_press = 0;
	logic [31:0] rnd = 32'h3351;

	digital_clock #(
		.TICKS_PER_SEC (4),
		.SCAN_DIV      (1)
	) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n) cyc <= cyc + 1;	// Edges since reset release
	end

	always @(posedge clk) begin
		if (cyc >= LIMIT) begin
			$display("Timeout: tests did not finish within %0d cycles", LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Seconds ticks applied up to and including edge j
	function automatic int ticks_in(input int j);
		return (j >= 5) ? (j - 5) / 4 + 1 : 0;
	endfunction

	// Running seconds shown on the outputs after edge k
	function automatic int shown_secs(input int k);
		return ticks_in(k - 1) - lost;
	endfunction

	function automatic hms_t secs_to_hms(input int s);
		hms_t t;
		t.hou = hms_field_t'((s / 3600) % 24);
		t.min = hms_field_t'((s / 60) % 60);
		t.sec = hms_field_t'(s % 60);
		return t;
	endfunction

	function automatic seg_t digit_seg(input hms_t t, input int idx);
		int v;
		int d;
		case (idx / 2)
			0:       v = int'(t.sec);
			1:       v = int'(t.min);
			default: v = int'(t.hou);
		endcase
		d = (idx % 2 == 1) ? v / 10 : v % 10;
		case (d)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic digit_dp(input int idx, input mode_e m, input pos_e p,
		input logic alm);
		if (alm) return 1'b1;
		if (m == MODE_SETUP) return idx == 2 * int'(p);
		if (m == MODE_ALARM) return idx == 2 * int'(p) + 1;
		return 1'b0;
	endfunction

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------
	task automatic check_seg(input string name, input seg_t exp, input seg_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s cycle %0d expected %b actual %b", name, cyc, exp, act);
		end
	endtask

	task automatic check_enb(input string name, input digit_sel_t exp, input digit_sel_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s cycle %0d expected %b actual %b", name, cyc, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s cycle %0d expected %b actual %b", name, cyc, exp, act);
		end
	endtask

	// Samples n scanned digits at the falling edge
	task automatic check_scan(input string name, input int n, input logic running,
		input hms_t fixed, input mode_e m, input pos_e p, input logic alm);
		hms_t t;
		int   k;
		int   idx;
		repeat (n) begin
			@(negedge clk);
			k = cyc;
			idx = (k < 2) ? 0 : (k - 2) % 6;
			t = running ? secs_to_hms(shown_secs(k)) : fixed;
			check_enb(name, digit_sel_t'(~(32'd1 << idx)), seg_enb);
			check_seg(name, digit_seg(t, idx), seg);
			check_bit(name, digit_dp(idx, m, p, alm), seg_dp);
		end
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic drive_btn(input int which, input logic val);
		case (which)
			B_MODE:  btn_mode <= val;
			B_POS:   btn_pos <= val;
			B_INC:   btn_inc <= val;
			default: btn_alarm <= val;
		endcase
	endtask

	task automatic press(input int which);
		@(negedge clk);
		last_press = cyc + 1;
		@(posedge clk);
		drive_btn(which, 1'b1);
		repeat (2) @(posedge clk);
		drive_btn(which, 1'b0);
		repeat (8) @(posedge clk);
	endtask

	task automatic press_n(input int which, input int n);
		repeat (n) press(which);
	endtask

	initial begin
		int   s_alarm;
		int   n_inc;
		int   a_first;
		int   k_exp;
		hms_t alarm_t;
		hms_t frz;

		rst_n     = 1'b0;
		btn_mode  = 1'b0;
		btn_pos   = 1'b0;
		btn_inc   = 1'b0;
		btn_alarm = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		check_scan("reset_scan", 12, 1'b1, '0, MODE_CLOCK, POS_SEC, 1'b0);
		check_bit("reset_alarm", 1'b0, alarm);

		// Alarm at 01:02:S, passing through setup costs a few seconds
		rnd = lcg_next(rnd);
		s_alarm = 10 + int'(rnd[23:16]) % 10;
		press(B_MODE);
		a_first = last_press;
		press(B_MODE);
		lost = ticks_in(last_press + 4) - ticks_in(a_first + 4);
		press_n(B_INC, s_alarm);
		press(B_POS);
		press_n(B_INC, 2);
		press(B_POS);
		press(B_INC);
		alarm_t = secs_to_hms(3720 + s_alarm);
		check_scan("alarm_display", 6, 1'b0, alarm_t, MODE_ALARM, POS_HOU, 1'b0);
		press(B_MODE);
		check_scan("clock_after_alarm", 6, 1'b1, '0, MODE_CLOCK, POS_SEC, 1'b0);
		press(B_ALARM);

		@(negedge clk);
		while (shown_secs(cyc + 1) != 3725) @(negedge clk);
		check_scan("running_time", 6, 1'b1, '0, MODE_CLOCK, POS_SEC, 1'b0);

		// ----------------------------------------------------------
		// Ringing
		// ----------------------------------------------------------
		k_exp = cyc;
		while (shown_secs(k_exp) != 3720 + s_alarm) k_exp++;
		while (!alarm && cyc < k_exp + 20) @(negedge clk);
		if (!alarm) begin
			errors++;
			$display("o_alarm never went high when the time reached the alarm setting");
		end else if (cyc != k_exp) begin
			errors++;
			$display("ERR alarm_rise expected cycle %0d actual cycle %0d", k_exp, cyc);
		end
		check_scan("alarm_ring", 6, 1'b1, '0, MODE_CLOCK, POS_SEC, 1'b1);
		press(B_ALARM);
		@(negedge clk);
		check_bit("alarm_off", 1'b0, alarm);

		// Setup of the hour field, time frozen
		rnd = lcg_next(rnd);
		n_inc = 1 + int'(rnd[23:16]) % 30;
		press(B_MODE);
		frz = secs_to_hms(ticks_in(last_press + 4) - lost);
		press_n(B_POS, 2);
		press_n(B_INC, n_inc);
		frz.hou = hms_field_t'((int'(frz.hou) + n_inc) % 24);
		check_scan("setup_hours", 12, 1'b0, frz, MODE_SETUP, POS_HOU, 1'b0);

		$display("Error count: %0d", errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tick_gen.sv ====
`default_nettype none

module tick_gen #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int SCAN_DIV      = 50_000
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick
);

	logic [31:0] sec_cnt;
	logic [31:0] scan_cnt;

	// One-second enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt    <= '0;
			o_sec_tick <= 1'b0;
		end else if (sec_cnt == 32'(TICKS_PER_SEC - 1)) begin
			sec_cnt    <= '0;
			o_sec_tick <= 1'b1;
		end else begin
			sec_cnt    <= sec_cnt + 32'd1;
			o_sec_tick <= 1'b0;
		end
	end

	// Digit scan enable, high every cycle when SCAN_DIV is 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt    <= '0;
			o_scan_tick <= 1'b0;
		end else if (scan_cnt == 32'(SCAN_DIV - 1)) begin
			scan_cnt    <= '0;
			o_scan_tick <= 1'b1;
		end else begin
			scan_cnt    <= scan_cnt + 32'd1;
			o_scan_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== time_keeper.sv ====
`default_nettype none

module time_keeper (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_sec_tick,
	input  wire clock_pkg::btn_t i_btn,
	input  wire clock_pkg::cfg_t i_cfg,
	output clock_pkg::hms_t      o_time,
	output clock_pkg::hms_t      o_alarm_set,
	output logic                 o_alarm
);

	import clock_pkg::*;

	// Step one field and wrap to zero past its limit
	function automatic hms_field_t step_field(hms_field_t v, hms_field_t lim);
		return (v >= lim) ? 6'd0 : v + 6'd1;
	endfunction

	// One second forward with carries
	function automatic hms_t step_time(hms_t t);
		hms_t n;
		n = t;
		n.sec = step_field(t.sec, SEC_MAX);
		if (t.sec == SEC_MAX) begin
			n.min = step_field(t.min, MIN_MAX);
			if (t.min == MIN_MAX) begin
				n.hou = step_field(t.hou, HOU_MAX);
			end
		end
		return n;
	endfunction

	// Only the selected field moves without carry
	function automatic hms_t step_pos(hms_t t, pos_e p);
		hms_t n;
		n = t;
		case (p)
			POS_SEC: n.sec = step_field(t.sec, SEC_MAX);
			POS_MIN: n.min = step_field(t.min, MIN_MAX);
			POS_HOU: n.hou = step_field(t.hou, HOU_MAX);
			default: n = t;
		endcase
		return n;
	endfunction

	// ----------------------------------------------------------
	// Running time
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else if (i_cfg.mode == MODE_SETUP) begin
			if (i_btn.inc) begin	// Frozen apart from edits
				o_time <= step_pos(o_time, i_cfg.pos);
			end
		end else if (i_sec_tick) begin
			o_time <= step_time(o_time);
		end
	end

	// ----------------------------------------------------------
	// Alarm setting and latch
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_set <= '0;
		end else if (i_cfg.mode == MODE_ALARM && i_btn.inc) begin
			o_alarm_set <= step_pos(o_alarm_set, i_cfg.pos);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			// Holds until disabled
			o_alarm <= i_cfg.alarm_en && (o_alarm || o_time == o_alarm_set);
		end
	end

	a_time_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_time.sec <= SEC_MAX && o_time.min <= MIN_MAX && o_time.hou <= HOU_MAX);

	a_alarm_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_alarm_set.sec <= SEC_MAX && o_alarm_set.min <= MIN_MAX &&
		o_alarm_set.hou <= HOU_MAX);

endmodule

`default_nettype wire
